//--- hw/bpu_pkg.sv
// shared types for the branch prediction unit
// pc, tag and counter widths plus the direction counter values
`default_nettype none

package bpu_pkg;

  localparam int unsigned PC_W  = 32;           // instruction address width
  localparam int unsigned TAG_W = PC_W - 2;     // word address width
  localparam int unsigned CTR_W = 2;            // direction counter width

  // instruction address
  typedef logic [PC_W-1:0]  pc_t;

  // word address, pc[31:2], kept whole so it is independent of index width
  typedef logic [TAG_W-1:0] tag_t;

  // saturating direction counter, msb set means predict taken
  typedef logic [CTR_W-1:0] ctr_t;

  localparam ctr_t CTR_STRONG_NT = 2'd0;        // strongly not taken
  localparam ctr_t CTR_WEAK_NT   = 2'd1;        // weakly not taken
  localparam ctr_t CTR_WEAK_T    = 2'd2;        // weakly taken, set on allocation
  localparam ctr_t CTR_STRONG_T  = 2'd3;        // strongly taken

endpackage : bpu_pkg

`default_nettype wire

//--- hw/bpu_if.sv
// lookup_if carries one looked-up item from the lookup stage to the select stage
// resolve_if carries a branch outcome from execute into the buffer
`timescale 1ns/100ps
`default_nettype none

interface lookup_if;
  logic              valid;       // item present in lookup stage
  logic              ready;       // select stage can take it
  bpu_pkg::pc_t      pc;          // fetch pc of the item
  logic              ent_valid;   // entry valid bit read from the array
  bpu_pkg::tag_t     ent_tag;     // stored word address
  bpu_pkg::pc_t      ent_target;  // stored branch target
  bpu_pkg::ctr_t     ent_ctr;     // stored direction counter

  modport src (
    output valid, pc, ent_valid, ent_tag, ent_target, ent_ctr,
    input  ready
  );

  modport dst (
    input  valid, pc, ent_valid, ent_tag, ent_target, ent_ctr,
    output ready
  );
endinterface : lookup_if

interface resolve_if;
  logic              valid;       // update strobe, always accepted
  bpu_pkg::pc_t      pc;          // pc of the resolved branch
  bpu_pkg::pc_t      target;      // actual target
  logic              taken;       // actual direction

  modport src (output valid, pc, target, taken);
  modport dst (input  valid, pc, target, taken);
endinterface : resolve_if

`default_nettype wire

//--- hw/btb_store.sv
// direct mapped branch target buffer storage
// registered read port and single cycle read-modify-write update port
`timescale 1ns/100ps
`default_nettype none

module btb_store #(
  parameter int unsigned INDEX_W = 6                // log2 of entry count
) (
  input  logic          clk_i,
  input  logic          arst_n_i,
  // read port
  input  logic          rd_en_i,                    // load read register
  input  bpu_pkg::pc_t  rd_pc_i,                    // lookup pc
  // update port
  input  logic          upd_valid_i,                // resolve strobe
  input  bpu_pkg::pc_t  upd_pc_i,                   // resolved branch pc
  input  bpu_pkg::pc_t  upd_target_i,               // resolved target
  input  logic          upd_taken_i,                // resolved direction
  // registered entry
  output logic          rd_valid_o,
  output bpu_pkg::tag_t rd_tag_o,
  output bpu_pkg::pc_t  rd_target_o,
  output bpu_pkg::ctr_t rd_ctr_o
);

  localparam int unsigned NUM_ENTRIES = 1 << INDEX_W;

  logic          valid_q  [NUM_ENTRIES];            // only array with reset
  bpu_pkg::tag_t tag_q    [NUM_ENTRIES];
  bpu_pkg::pc_t  target_q [NUM_ENTRIES];
  bpu_pkg::ctr_t ctr_q    [NUM_ENTRIES];

  logic [INDEX_W-1:0] rd_idx;
  logic [INDEX_W-1:0] upd_idx;
  bpu_pkg::tag_t      upd_tag;
  bpu_pkg::ctr_t      upd_ctr_cur;                  // counter of indexed entry
  bpu_pkg::ctr_t      upd_ctr_nxt;                  // counter after the step
  logic               upd_match;                    // update hits a live entry

  assign rd_idx  = rd_pc_i[INDEX_W+1:2];            // word index
  assign upd_idx = upd_pc_i[INDEX_W+1:2];
  assign upd_tag = upd_pc_i[31:2];                  // whole word address

  assign upd_match   = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);
  assign upd_ctr_cur = ctr_q[upd_idx];

  // saturating step, no wrap at either end
  always_comb begin
    upd_ctr_nxt = upd_ctr_cur;
    if (upd_taken_i) begin
      if (upd_ctr_cur != bpu_pkg::CTR_STRONG_T) begin
        upd_ctr_nxt = upd_ctr_cur + 2'd1;
      end
    end else begin
      if (upd_ctr_cur != bpu_pkg::CTR_STRONG_NT) begin
        upd_ctr_nxt = upd_ctr_cur - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;                         // empty buffer after reset
      end
    end else if (upd_valid_i && !upd_match && upd_taken_i) begin
      valid_q[upd_idx] <= 1'b1;                     // allocate on taken miss
    end
  end

  // payload arrays, not-taken miss leaves entry alone
  always_ff @(posedge clk_i) begin
    if (upd_valid_i) begin
      if (upd_match) begin
        ctr_q[upd_idx] <= upd_ctr_nxt;
        if (upd_taken_i) begin
          target_q[upd_idx] <= upd_target_i;        // refresh target
        end
      end else if (upd_taken_i) begin
        tag_q[upd_idx]    <= upd_tag;               // replace the entry
        target_q[upd_idx] <= upd_target_i;
        ctr_q[upd_idx]    <= bpu_pkg::CTR_WEAK_T;
      end
    end
  end

  // read register samples old contents on an update edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_valid_o <= 1'b0;
    end else if (rd_en_i) begin
      rd_valid_o <= valid_q[rd_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_tag_o    <= tag_q[rd_idx];
      rd_target_o <= target_q[rd_idx];
      rd_ctr_o    <= ctr_q[rd_idx];
    end
  end

endmodule : btb_store

`default_nettype wire

//--- hw/btb_lookup.sv
// first pipeline stage of the predictor
// accepts fetch requests, reads the buffer and holds the item for the select stage
`timescale 1ns/100ps
`default_nettype none

module btb_lookup #(
  parameter int unsigned INDEX_W = 6                // log2 of entry count
) (
  input  logic          clk_i,
  input  logic          arst_n_i,
  // fetch request
  input  logic          req_valid_i,
  input  bpu_pkg::pc_t  req_pc_i,
  output logic          req_ready_o,
  // execute stage update
  resolve_if.dst        rsv,
  // towards select stage
  lookup_if.src         lk
);

  logic          lk_valid_q;                        // stage holds an item
  bpu_pkg::pc_t  lk_pc_q;                           // pc of held item
  logic          req_accept;                        // request handshake

  logic          ent_valid;
  bpu_pkg::tag_t ent_tag;
  bpu_pkg::pc_t  ent_target;
  bpu_pkg::ctr_t ent_ctr;

  // free when empty or when the held item leaves this edge
  assign req_ready_o = !lk_valid_q || lk.ready;
  assign req_accept  = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lk_valid_q <= 1'b0;
    end else if (req_accept) begin
      lk_valid_q <= 1'b1;
    end else if (lk.ready) begin
      lk_valid_q <= 1'b0;                           // drained, nothing new
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      lk_pc_q <= req_pc_i;
    end
  end

  // read register only moves on acceptance so a stalled item stays stable
  btb_store #(
    .INDEX_W      (INDEX_W)
  ) btb_store_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .rd_en_i      (req_accept),
    .rd_pc_i      (req_pc_i),
    .upd_valid_i  (rsv.valid),
    .upd_pc_i     (rsv.pc),
    .upd_target_i (rsv.target),
    .upd_taken_i  (rsv.taken),
    .rd_valid_o   (ent_valid),
    .rd_tag_o     (ent_tag),
    .rd_target_o  (ent_target),
    .rd_ctr_o     (ent_ctr)
  );

  assign lk.valid      = lk_valid_q;
  assign lk.pc         = lk_pc_q;
  assign lk.ent_valid  = ent_valid;
  assign lk.ent_tag    = ent_tag;
  assign lk.ent_target = ent_target;
  assign lk.ent_ctr    = ent_ctr;

endmodule : btb_lookup

`default_nettype wire

//--- hw/pred_select.sv
// second pipeline stage of the predictor
// tag compare and counter decode feeding the registered prediction output
`timescale 1ns/100ps
`default_nettype none

module pred_select (
  input  logic          clk_i,
  input  logic          arst_n_i,
  // from lookup stage
  lookup_if.dst         lk,
  // prediction output
  input  logic          pred_ready_i,
  output logic          pred_valid_o,
  output bpu_pkg::pc_t  pred_pc_o,
  output logic          pred_hit_o,
  output logic          pred_taken_o,
  output bpu_pkg::pc_t  pred_next_pc_o
);

  logic          out_valid_q;                       // output register full
  logic          out_load;                          // item moves in this edge

  logic          sel_hit;
  logic          sel_taken;
  bpu_pkg::pc_t  sel_fall;                          // sequential pc
  bpu_pkg::pc_t  sel_next;

  // tag is the full word address of the fetch pc
  assign sel_hit   = lk.ent_valid && (lk.ent_tag == lk.pc[31:2]);
  assign sel_taken = sel_hit && lk.ent_ctr[1];      // counter msb gives direction
  assign sel_fall  = lk.pc + 32'd4;
  assign sel_next  = sel_taken ? lk.ent_target : sel_fall;

  // take a new item when empty or draining
  assign lk.ready = !out_valid_q || pred_ready_i;
  assign out_load = lk.valid && lk.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (lk.ready) begin
      out_valid_q <= lk.valid;                      // refill or go empty
    end
  end

  // payload holds while the consumer stalls
  always_ff @(posedge clk_i) begin
    if (out_load) begin
      pred_pc_o      <= lk.pc;
      pred_hit_o     <= sel_hit;
      pred_taken_o   <= sel_taken;
      pred_next_pc_o <= sel_next;
    end
  end

  assign pred_valid_o = out_valid_q;

endmodule : pred_select

`default_nettype wire

//--- hw/bpu_top.sv
// branch prediction unit top level
// plain ports wired to the lookup and select stages through two bundles
`timescale 1ns/100ps
`default_nettype none

module bpu_top #(
  parameter int unsigned INDEX_W = 6                // 64 entries by default
) (
  input  logic          clk_i,
  input  logic          arst_n_i,
  // fetch request
  input  logic          req_valid_i,
  input  bpu_pkg::pc_t  req_pc_i,
  output logic          req_ready_o,
  // resolve from execute, no back-pressure
  input  logic          rsv_valid_i,
  input  bpu_pkg::pc_t  rsv_pc_i,
  input  bpu_pkg::pc_t  rsv_target_i,
  input  logic          rsv_taken_i,
  // prediction to fetch
  input  logic          pred_ready_i,
  output logic          pred_valid_o,
  output bpu_pkg::pc_t  pred_pc_o,
  output logic          pred_hit_o,
  output logic          pred_taken_o,
  output bpu_pkg::pc_t  pred_next_pc_o
);

  lookup_if  lk_if ();                              // stage 1 to stage 2
  resolve_if rsv_if ();                             // buffer update bundle

  assign rsv_if.valid  = rsv_valid_i;
  assign rsv_if.pc     = rsv_pc_i;
  assign rsv_if.target = rsv_target_i;
  assign rsv_if.taken  = rsv_taken_i;

  btb_lookup #(
    .INDEX_W        (INDEX_W)
  ) btb_lookup_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .req_valid_i    (req_valid_i),
    .req_pc_i       (req_pc_i),
    .req_ready_o    (req_ready_o),
    .rsv            (rsv_if.dst),
    .lk             (lk_if.src)
  );

  pred_select pred_select_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .lk             (lk_if.dst),
    .pred_ready_i   (pred_ready_i),
    .pred_valid_o   (pred_valid_o),
    .pred_pc_o      (pred_pc_o),
    .pred_hit_o     (pred_hit_o),
    .pred_taken_o   (pred_taken_o),
    .pred_next_pc_o (pred_next_pc_o)
  );

endmodule : bpu_top

`default_nettype wire

//--- tb/tb_bpu_tasks.svh
// driver, compare and directed test tasks for the predictor testbench
// included into the testbench module body
`ifndef TB_BPU_TASKS_SVH
`define TB_BPU_TASKS_SVH

  task automatic check_pc(input string name, input bpu_pkg::pc_t got, input bpu_pkg::pc_t exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
      mismatch_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
      mismatch_errs++;
    end
  endtask

  task automatic compare_output();
    pred_t exp;
    if (exp_q.size() == 0) begin
      $display("prediction for pc %h arrived with no request outstanding", pred_pc_o);
      other_errs++;
    end else begin
      exp = exp_q.pop_front();
      check_pc("pred_pc_o", pred_pc_o, exp.pc);
      check_bit("pred_hit_o", pred_hit_o, exp.hit);
      check_bit("pred_taken_o", pred_taken_o, exp.taken);
      check_pc("pred_next_pc_o", pred_next_pc_o, exp.next_pc);
    end
  endtask

  // called on a falling edge with inputs set, returns on the next falling edge
  task automatic tick();
    #1;                                             // ready paths have settled
    last_accept = req_valid_i && req_ready_o;
    if (pred_valid_o && pred_ready_i) begin
      compare_output();
    end
    if (last_accept) begin
      exp_q.push_back(predict(req_pc_i));           // read sees the old contents
    end
    if (rsv_valid_i) begin
      model_update(rsv_pc_i, rsv_target_i, rsv_taken_i);
    end
    @(negedge clk_i);
  endtask

  task automatic send_request(input bpu_pkg::pc_t pc);
    int waited;
    waited       = 0;
    req_valid_i  = 1'b1;
    req_pc_i     = pc;
    pred_ready_i = 1'b1;
    tick();
    while (!last_accept && waited < 50) begin
      tick();
      waited++;
    end
    if (!last_accept) begin
      $display("request for pc %h was never accepted", pc);
      other_errs++;
    end
    req_valid_i = 1'b0;
  endtask

  task automatic send_resolve(input bpu_pkg::pc_t pc, input bpu_pkg::pc_t target,
                              input logic taken);
    rsv_valid_i  = 1'b1;
    rsv_pc_i     = pc;
    rsv_target_i = target;
    rsv_taken_i  = taken;
    tick();
    rsv_valid_i  = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited       = 0;
    req_valid_i  = 1'b0;
    rsv_valid_i  = 1'b0;
    pred_ready_i = 1'b1;
    while (exp_q.size() != 0 && waited < 100) begin
      tick();
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("output stalled with %0d predictions still missing", exp_q.size());
      other_errs++;
      exp_q.delete();
    end
  endtask

  task automatic cold_miss();
    send_request(32'h0000_0100);
    send_request(32'h0000_0204);
    send_request(32'h0000_03f8);
    send_request(32'hffff_fffc);                    // pc plus 4 wraps
    drain();
  endtask

  task automatic allocate_on_taken();
    send_resolve(32'h0000_2040, 32'h0000_3000, 1'b1);
    send_request(32'h0000_2040);                    // expect weak taken hit
    drain();
  endtask

  // entry starts at weak taken from the allocation test
  task automatic walk_counter();
    repeat (3) begin
      send_resolve(32'h0000_2040, 32'h0000_3000, 1'b0);
      send_request(32'h0000_2040);
    end
    repeat (4) begin
      send_resolve(32'h0000_2040, 32'h0000_3100, 1'b1);
      send_request(32'h0000_2040);
    end
    send_resolve(32'h0000_2040, 32'h0000_3100, 1'b0);
    send_request(32'h0000_2040);                    // back to weak taken
    drain();
  endtask

  task automatic alias_replace();
    bpu_pkg::pc_t pc_a;
    bpu_pkg::pc_t pc_b;
    pc_a = 32'h0000_5010;
    pc_b = pc_a + (32'd1 << (INDEX_W + 2));         // same index, other tag
    send_resolve(pc_a, 32'h0000_6000, 1'b1);
    send_request(pc_a);
    send_request(pc_b);
    send_resolve(pc_b, 32'h0000_7000, 1'b0);        // not taken miss, no change
    send_request(pc_a);
    send_resolve(pc_b, 32'h0000_7000, 1'b1);        // evicts pc_a
    send_request(pc_a);
    send_request(pc_b);
    drain();
  endtask

  task automatic stall_output();
    bpu_pkg::pc_t pc;
    int           taken_cnt;
    pc           = 32'h0000_9000;
    taken_cnt    = 0;
    pred_ready_i = 1'b0;
    req_valid_i  = 1'b1;
    for (int i = 0; i < 8; i++) begin
      req_pc_i = pc;
      tick();
      if (!last_accept) begin
        break;                                      // req_ready_o has fallen
      end
      pc = pc + 32'd4;
      taken_cnt++;
    end
    req_valid_i = 1'b0;
    if (taken_cnt != 2) begin
      $display("%0d requests accepted under back-pressure instead of 2", taken_cnt);
      other_errs++;
    end
    repeat (3) begin
      tick();
      check_bit("pred_valid_o", pred_valid_o, 1'b1);  // output held
      check_bit("req_ready_o", req_ready_o, 1'b0);
    end
    drain();
  endtask

  // four tags over eight indices
  function automatic bpu_pkg::pc_t random_pc(input logic [7:0] r);
    return 32'h0000_1000 + {r[7:6], 8'h00} + {r[2:0], 2'b00};
  endfunction

  function automatic logic index_busy(input bpu_pkg::pc_t pc);
    foreach (exp_q[i]) begin
      if (exp_q[i].pc[INDEX_W+1:2] == pc[INDEX_W+1:2]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic random_mix();
    logic [31:0]  rnd;
    bpu_pkg::pc_t pc;
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd          = $random(seed);
      pred_ready_i = rnd[0] | rnd[1];               // ready three cycles in four
      if (!req_valid_i || last_accept) begin        // a pending request holds
        req_valid_i = rnd[2] | rnd[3];
        req_pc_i    = random_pc(rnd[15:8]);
      end
      pc           = random_pc(rnd[23:16]);
      rsv_valid_i  = rnd[4] && !index_busy(pc);
      rsv_pc_i     = pc;
      rsv_target_i = 32'h0000_8000 + {rnd[31:24], 2'b00};
      rsv_taken_i  = rnd[5];
      tick();
    end
    drain();
  endtask

`endif

//--- tb/tb_bpu.sv
// testbench top for the branch prediction unit
// clock, reset, DUT, shadow buffer model, watchdog and test sequence
`timescale 1ns/100ps
`default_nettype none

module tb_bpu;

  localparam int INDEX_W       = 6;
  localparam int ENTRIES       = 1 << INDEX_W;
  localparam int DIRECTED_REQS = 30;                // bound on directed requests
  localparam int N_RANDOM      = 300;               // random traffic cycles
  localparam int WATCHDOG_CYC  = (DIRECTED_REQS + N_RANDOM) * 20 + 200;

  typedef struct packed {
    bpu_pkg::pc_t pc;
    logic         hit;
    logic         taken;
    bpu_pkg::pc_t next_pc;
  } pred_t;

  logic         clk_i;
  logic         arst_n_i;
  logic         req_valid_i;
  bpu_pkg::pc_t req_pc_i;
  logic         req_ready_o;
  logic         rsv_valid_i;
  bpu_pkg::pc_t rsv_pc_i;
  bpu_pkg::pc_t rsv_target_i;
  logic         rsv_taken_i;
  logic         pred_ready_i;
  logic         pred_valid_o;
  bpu_pkg::pc_t pred_pc_o;
  logic         pred_hit_o;
  logic         pred_taken_o;
  bpu_pkg::pc_t pred_next_pc_o;

  // shadow copy of the buffer
  logic          m_valid  [ENTRIES];
  bpu_pkg::tag_t m_tag    [ENTRIES];
  bpu_pkg::pc_t  m_target [ENTRIES];
  bpu_pkg::ctr_t m_ctr    [ENTRIES];

  pred_t  exp_q [$];                                // predictions in flight, oldest first
  int     mismatch_errs;
  int     other_errs;
  logic   last_accept;                              // request taken at the last edge
  integer seed;

  bpu_top #(
    .INDEX_W        (INDEX_W)
  ) bpu_top_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .req_valid_i    (req_valid_i),
    .req_pc_i       (req_pc_i),
    .req_ready_o    (req_ready_o),
    .rsv_valid_i    (rsv_valid_i),
    .rsv_pc_i       (rsv_pc_i),
    .rsv_target_i   (rsv_target_i),
    .rsv_taken_i    (rsv_taken_i),
    .pred_ready_i   (pred_ready_i),
    .pred_valid_o   (pred_valid_o),
    .pred_pc_o      (pred_pc_o),
    .pred_hit_o     (pred_hit_o),
    .pred_taken_o   (pred_taken_o),
    .pred_next_pc_o (pred_next_pc_o)
  );

  // expected prediction from the current shadow contents
  function automatic pred_t predict(input bpu_pkg::pc_t pc);
    pred_t p;
    int    idx;
    idx       = pc[INDEX_W+1:2];
    p.pc      = pc;
    p.hit     = m_valid[idx] && (m_tag[idx] == pc[31:2]);
    p.taken   = p.hit && m_ctr[idx][1];             // msb gives direction
    p.next_pc = p.taken ? m_target[idx] : pc + 32'd4;
    return p;
  endfunction

  task automatic model_update(input bpu_pkg::pc_t pc, input bpu_pkg::pc_t target,
                              input logic taken);
    int idx;
    idx = pc[INDEX_W+1:2];
    if (m_valid[idx] && (m_tag[idx] == pc[31:2])) begin
      if (taken) begin
        m_target[idx] = target;
        if (m_ctr[idx] != bpu_pkg::CTR_STRONG_T) begin
          m_ctr[idx] = m_ctr[idx] + 2'd1;           // count up, stop at 3
        end
      end else if (m_ctr[idx] != bpu_pkg::CTR_STRONG_NT) begin
        m_ctr[idx] = m_ctr[idx] - 2'd1;             // count down, stop at 0
      end
    end else if (taken) begin
      m_valid[idx]  = 1'b1;                         // allocate, replacing any alias
      m_tag[idx]    = pc[31:2];
      m_target[idx] = target;
      m_ctr[idx]    = bpu_pkg::CTR_WEAK_T;
    end
  endtask

`include "tb_bpu_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;                     // 40 ns period
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYC);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    seed          = 28094;
    mismatch_errs = 0;
    other_errs    = 0;
    last_accept   = 1'b0;
    for (int i = 0; i < ENTRIES; i++) begin
      m_valid[i] = 1'b0;                            // buffer empty after reset
    end
    arst_n_i     = 1'b0;
    req_valid_i  = 1'b0;
    req_pc_i     = '0;
    rsv_valid_i  = 1'b0;
    rsv_pc_i     = '0;
    rsv_target_i = '0;
    rsv_taken_i  = 1'b0;
    pred_ready_i = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("pred_valid_o", pred_valid_o, 1'b0);
    cold_miss();
    allocate_on_taken();
    walk_counter();
    alias_replace();
    stall_output();
    random_mix();
    $display("%0d value mismatches, %0d other errors", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_bpu

`default_nettype wire

//--- bpu.f
+incdir+tb
hw/bpu_pkg.sv
hw/bpu_if.sv
hw/btb_store.sv
hw/btb_lookup.sv
hw/pred_select.sv
hw/bpu_top.sv
tb/tb_bpu.sv

//--- Bender.yml
package:
  name: bpu

sources:
  - files:
      - hw/bpu_pkg.sv
      - hw/bpu_if.sv
      - hw/btb_store.sv
      - hw/btb_lookup.sv
      - hw/pred_select.sv
      - hw/bpu_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_bpu.sv
